//--- logic/lbp_pkg.sv
// ----------------------------------------
// Local branch predictor package
// Table sizes, PC field positions and the
// structs shared by the predictor blocks
// ----------------------------------------

`default_nettype none

package lbp_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int unsigned VLEN         = 32;
  localparam int unsigned SLOTS        = 2;
  localparam int unsigned SLOT_BITS    = 1;
  localparam int unsigned LHR_ROWS     = 16;
  localparam int unsigned LHR_ROW_BITS = 4;
  localparam int unsigned PHT_ROWS     = 16;
  localparam int unsigned HIST_BITS    = 4;
  localparam int unsigned CTR_BITS     = 2;
  localparam int unsigned CTR_RESET    = 2;

  // One clear walks the larger of the two tables
  localparam int unsigned CLEAR_ROWS     = 16;
  localparam int unsigned CLEAR_ROW_BITS = $clog2(CLEAR_ROWS);

  // PC layout: bit 0 is the compressed offset, then slot, then history row
  localparam int unsigned OFFSET  = 1;
  localparam int unsigned ROW_LSB = OFFSET + SLOT_BITS;

  typedef logic [VLEN-1:0]      pc_t;
  typedef logic [HIST_BITS-1:0] hist_t;

  // Resolved branch from execute
  typedef struct packed {
    logic valid;
    pc_t  pc;
    logic taken;
  } bht_update_t;

  typedef struct packed {
    logic valid;
    logic taken;
  } bht_prediction_t;

  // One pattern table entry
  typedef struct packed {
    logic                valid;
    logic [CTR_BITS-1:0] ctr;
  } lbp_entry_t;

  // Update admitted by the controller
  typedef struct packed {
    logic                    en;
    logic [SLOT_BITS-1:0]    slot;
    logic [LHR_ROW_BITS-1:0] row;
    logic                    taken;
  } lbp_write_t;

  typedef struct packed {
    logic                      active;
    logic [CLEAR_ROW_BITS-1:0] row;
  } lbp_clear_t;

endpackage

`default_nettype wire

//--- logic/lbp_sat_counter.sv
// ----------------------------------------
// Saturating branch counter step
// Moves one step toward the outcome
// ----------------------------------------

`default_nettype none

module lbp_sat_counter (
  input  logic [lbp_pkg::CTR_BITS-1:0] ctr_i,
  input  logic                         taken_i,
  output logic [lbp_pkg::CTR_BITS-1:0] ctr_o
);
  import lbp_pkg::*;

  logic at_max;
  logic at_min;

  assign at_max = &ctr_i;
  assign at_min = ~|ctr_i;

  always_comb begin
    ctr_o = ctr_i;
    if (taken_i) begin
      if (!at_max) begin
        ctr_o = ctr_i + CTR_BITS'(1);
      end
    end else if (!at_min) begin
      ctr_o = ctr_i - CTR_BITS'(1);
    end
  end

endmodule

`default_nettype wire

//--- logic/lbp_update_ctrl.sv
// ----------------------------------------
// Predictor update control
// Walks table clears after reset and flush,
// and admits resolved branch updates
// ----------------------------------------

`default_nettype none

module lbp_update_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_bp_i,
  input  logic                 debug_mode_i,
  input  lbp_pkg::bht_update_t bht_update_i,
  output lbp_pkg::lbp_write_t  write_o,
  output lbp_pkg::lbp_clear_t  clear_o,
  output logic                 busy_o
);
  import lbp_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_CLEAR
  } state_e;

  state_e                    state_q, state_d;
  logic [CLEAR_ROW_BITS-1:0] row_q, row_d;
  logic                      last_row;

  assign last_row = (row_q == CLEAR_ROW_BITS'(CLEAR_ROWS - 1));

  // ----------------------------------------
  // Clear sequencing
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    row_d   = row_q;
    // A flush always restarts the walk at row 0
    if (flush_bp_i) begin
      state_d = ST_CLEAR;
      row_d   = '0;
    end else if (state_q == ST_CLEAR) begin
      if (last_row) begin
        state_d = ST_IDLE;
        row_d   = '0;
      end else begin
        row_d = row_q + CLEAR_ROW_BITS'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_CLEAR;
      row_q   <= '0;
    end else begin
      state_q <= state_d;
      row_q   <= row_d;
    end
  end

  assign busy_o         = (state_q == ST_CLEAR);
  assign clear_o.active = busy_o;
  assign clear_o.row    = row_q;

  // ----------------------------------------
  // Update admission and PC decode
  // ----------------------------------------
  assign write_o.en    = bht_update_i.valid & ~debug_mode_i & ~busy_o;
  assign write_o.slot  = bht_update_i.pc[OFFSET +: SLOT_BITS];
  assign write_o.row   = bht_update_i.pc[ROW_LSB +: LHR_ROW_BITS];
  assign write_o.taken = bht_update_i.taken;

endmodule

`default_nettype wire

//--- logic/lbp_history_table.sv
// ----------------------------------------
// Local history registers
// One shift register per row and slot,
// read by fetch PC, shifted on update
// ----------------------------------------

`default_nettype none

module lbp_history_table (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  lbp_pkg::pc_t                          vpc_i,
  input  lbp_pkg::lbp_write_t                   write_i,
  input  lbp_pkg::lbp_clear_t                   clear_i,
  output lbp_pkg::hist_t [lbp_pkg::SLOTS-1:0]   hist_o
);
  import lbp_pkg::*;

  hist_t                   lhr_q [LHR_ROWS][SLOTS];
  logic [LHR_ROW_BITS-1:0] rd_row;
  logic [LHR_ROW_BITS-1:0] clr_row;
  hist_t                   wr_old;
  hist_t                   wr_new;

  assign rd_row  = vpc_i[ROW_LSB +: LHR_ROW_BITS];
  assign clr_row = LHR_ROW_BITS'(clear_i.row);

  // ----------------------------------------
  // Prediction read
  // ----------------------------------------
  for (genvar s = 0; s < SLOTS; s++) begin : gen_read
    assign hist_o[s] = lhr_q[rd_row][s];
  end

  // Newest outcome enters at bit 0
  assign wr_old = lhr_q[write_i.row][write_i.slot];
  assign wr_new = {wr_old[HIST_BITS-2:0], write_i.taken};

  // ----------------------------------------
  // Update shift and row clear
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < LHR_ROWS; r++) begin
        for (int s = 0; s < SLOTS; s++) begin
          lhr_q[r][s] <= '0;
        end
      end
    end else if (clear_i.active) begin
      for (int s = 0; s < SLOTS; s++) begin
        lhr_q[clr_row][s] <= '0;
      end
    end else if (write_i.en) begin
      lhr_q[write_i.row][write_i.slot] <= wr_new;
    end
  end

endmodule

`default_nettype wire

//--- logic/lbp_pattern_table.sv
// ----------------------------------------
// Pattern history table
// 2-bit counters per slot, indexed by the
// local history word of that slot
// ----------------------------------------

`default_nettype none

module lbp_pattern_table (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  lbp_pkg::hist_t [lbp_pkg::SLOTS-1:0]           hist_i,
  input  lbp_pkg::hist_t                                update_index_i,
  input  lbp_pkg::lbp_write_t                           write_i,
  input  lbp_pkg::lbp_clear_t                           clear_i,
  output lbp_pkg::bht_prediction_t [lbp_pkg::SLOTS-1:0] bht_prediction_o
);
  import lbp_pkg::*;

  lbp_entry_t          pht_q [PHT_ROWS][SLOTS];
  lbp_entry_t          rd_entry [SLOTS];
  lbp_entry_t          wr_entry;
  logic [CTR_BITS-1:0] cur_ctr;
  logic [CTR_BITS-1:0] next_ctr;
  hist_t               clr_row;

  assign clr_row = HIST_BITS'(clear_i.row);

  // ----------------------------------------
  // Prediction read
  // ----------------------------------------
  for (genvar s = 0; s < SLOTS; s++) begin : gen_read
    assign rd_entry[s] = pht_q[hist_i[s]][s];
    // Table contents are stale while the walk is running
    assign bht_prediction_o[s].valid = rd_entry[s].valid & ~clear_i.active;
    assign bht_prediction_o[s].taken = rd_entry[s].ctr[CTR_BITS-1];
  end

  // ----------------------------------------
  // Update counter step
  // ----------------------------------------
  assign cur_ctr = pht_q[update_index_i][write_i.slot].ctr;

  lbp_sat_counter u_sat_counter (
    .ctr_i   (cur_ctr),
    .taken_i (write_i.taken),
    .ctr_o   (next_ctr)
  );

  assign wr_entry.valid = 1'b1;
  assign wr_entry.ctr   = next_ctr;

  // Cleared entries are invalid and weakly taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < PHT_ROWS; r++) begin
        for (int s = 0; s < SLOTS; s++) begin
          pht_q[r][s].valid <= 1'b0;
          pht_q[r][s].ctr   <= CTR_BITS'(CTR_RESET);
        end
      end
    end else if (clear_i.active) begin
      for (int s = 0; s < SLOTS; s++) begin
        pht_q[clr_row][s].valid <= 1'b0;
        pht_q[clr_row][s].ctr   <= CTR_BITS'(CTR_RESET);
      end
    end else if (write_i.en) begin
      pht_q[update_index_i][write_i.slot] <= wr_entry;
    end
  end

endmodule

`default_nettype wire

//--- logic/lbp_top.sv
// ----------------------------------------
// Two-level local branch predictor
// History registers select per-slot
// saturating counters, two slots per fetch
// ----------------------------------------

`default_nettype none

module lbp_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          flush_bp_i,
  input  logic                                          debug_mode_i,
  input  lbp_pkg::pc_t                                  vpc_i,
  input  lbp_pkg::bht_update_t                          bht_update_i,
  input  lbp_pkg::hist_t                                update_index_i,
  output lbp_pkg::bht_prediction_t [lbp_pkg::SLOTS-1:0] bht_prediction_o,
  output lbp_pkg::hist_t [lbp_pkg::SLOTS-1:0]           index_o,
  output logic                                          busy_o
);
  import lbp_pkg::*;

  lbp_write_t           write;
  lbp_clear_t           clear;
  hist_t [SLOTS-1:0]    lhr_hist;

  // Clear sequencing and update admission
  lbp_update_ctrl u_update_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_bp_i   (flush_bp_i),
    .debug_mode_i (debug_mode_i),
    .bht_update_i (bht_update_i),
    .write_o      (write),
    .clear_o      (clear),
    .busy_o       (busy_o)
  );

  // First level
  lbp_history_table u_history_table (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .vpc_i   (vpc_i),
    .write_i (write),
    .clear_i (clear),
    .hist_o  (lhr_hist)
  );

  // Second level
  lbp_pattern_table u_pattern_table (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .hist_i           (lhr_hist),
    .update_index_i   (update_index_i),
    .write_i          (write),
    .clear_i          (clear),
    .bht_prediction_o (bht_prediction_o)
  );

  // Frontend keeps this word and returns it with the update
  assign index_o = lhr_hist;

endmodule

`default_nettype wire

//--- bench/tb_lbp_top.sv
// ----------------------------------------
// Local branch predictor testbench
// Mirrors both tables in a model and
// checks predictions with assertions
// ----------------------------------------

`default_nettype none

module tb_lbp_top;
  timeunit 1ns;
  timeprecision 100ps;

  import lbp_pkg::*;

  localparam int unsigned WAIT_LIMIT = 40;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        flush_bp_i;
  logic                        debug_mode_i;
  pc_t                         vpc_i;
  bht_update_t                 bht_update_i;
  hist_t                       update_index_i;
  bht_prediction_t [SLOTS-1:0] bht_prediction_o;
  hist_t [SLOTS-1:0]           index_o;
  logic                        busy_o;

  // Model of both tables
  hist_t               ref_lhr [LHR_ROWS][SLOTS];
  logic                ref_valid [PHT_ROWS][SLOTS];
  logic [CTR_BITS-1:0] ref_ctr [PHT_ROWS][SLOTS];
  logic                clearing;

  int unsigned checks;
  int unsigned errors;
  int unsigned cycles;
  pc_t         pc;

  lbp_top i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_bp_i       (flush_bp_i),
    .debug_mode_i     (debug_mode_i),
    .vpc_i            (vpc_i),
    .bht_update_i     (bht_update_i),
    .update_index_i   (update_index_i),
    .bht_prediction_o (bht_prediction_o),
    .index_o          (index_o),
    .busy_o           (busy_o)
  );

  always #4 clk_i = ~clk_i;

  // Next drive point, 1 ns after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_equal(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic clear_model();
    for (int r = 0; r < LHR_ROWS; r++) begin
      for (int s = 0; s < SLOTS; s++) begin
        ref_lhr[r][s] = '0;
      end
    end
    for (int r = 0; r < PHT_ROWS; r++) begin
      for (int s = 0; s < SLOTS; s++) begin
        ref_valid[r][s] = 1'b0;
        ref_ctr[r][s]   = CTR_BITS'(CTR_RESET);
      end
    end
  endtask

  // Counts busy cycles from a drive point and ends on the next drive point
  task automatic wait_idle(output int unsigned n);
    n = 0;
    #2;
    while (busy_o && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #3;
      n++;
    end
    if (busy_o) begin
      $display("Timeout: busy_o still high after %0d cycles", WAIT_LIMIT);
      $display("Test failed");
      $finish;
    end else begin
      tick();
    end
  endtask

  task automatic start_flush();
    flush_bp_i = 1'b1;
    tick();
    flush_bp_i = 1'b0;
  endtask

  task automatic do_update(input pc_t addr, input logic taken, input logic debug);
    logic [SLOT_BITS-1:0]    slot;
    logic [LHR_ROW_BITS-1:0] row;
    hist_t                   h;
    slot = addr[OFFSET +: SLOT_BITS];
    row  = addr[ROW_LSB +: LHR_ROW_BITS];
    h    = ref_lhr[row][slot];
    bht_update_i.valid = 1'b1;
    bht_update_i.pc    = addr;
    bht_update_i.taken = taken;
    update_index_i     = h;
    debug_mode_i       = debug;
    if (!debug && !clearing) begin
      ref_valid[h][slot] = 1'b1;
      if (taken && ref_ctr[h][slot] != {CTR_BITS{1'b1}}) begin
        ref_ctr[h][slot] = ref_ctr[h][slot] + 1'b1;
      end else if (!taken && ref_ctr[h][slot] != '0) begin
        ref_ctr[h][slot] = ref_ctr[h][slot] - 1'b1;
      end
      ref_lhr[row][slot] = {h[HIST_BITS-2:0], taken};
    end
    tick();
    bht_update_i.valid = 1'b0;
    debug_mode_i       = 1'b0;
  endtask

  // Both slots of the fetch row, sampled mid-cycle
  task automatic check_pc(input pc_t addr);
    logic [LHR_ROW_BITS-1:0] row;
    hist_t                   h;
    row   = addr[ROW_LSB +: LHR_ROW_BITS];
    vpc_i = addr;
    #2;
    for (int s = 0; s < SLOTS; s++) begin
      h = ref_lhr[row][s];
      check_equal(int'(index_o[s]), int'(h), $sformatf("index_o[%0d] row %0d", s, row));
      check_equal(int'(bht_prediction_o[s].valid), int'(ref_valid[h][s]),
                  $sformatf("valid slot %0d row %0d", s, row));
      check_equal(int'(bht_prediction_o[s].taken), int'(ref_ctr[h][s][CTR_BITS-1]),
                  $sformatf("taken slot %0d row %0d", s, row));
    end
    tick();
  endtask

  task automatic check_all();
    for (int r = 0; r < LHR_ROWS; r++) begin
      check_pc(pc_t'(r) << ROW_LSB);
    end
  endtask

  initial begin
    void'($urandom(72));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    flush_bp_i     = 1'b0;
    debug_mode_i   = 1'b0;
    vpc_i          = '0;
    bht_update_i   = '0;
    update_index_i = '0;
    checks         = 0;
    errors         = 0;
    clearing       = 1'b0;
    clear_model();
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_idle(cycles);
    check_equal(int'(cycles), int'(CLEAR_ROWS), "busy cycles after reset");
    check_all();

    // Train row 9 slot 0 up to saturation, then down
    for (int i = 0; i < 8; i++) begin
      do_update(32'h24, 1'b1, 1'b0);
      check_pc(32'h24);
    end
    for (int i = 0; i < 8; i++) begin
      do_update(32'h24, 1'b0, 1'b0);
      check_pc(32'h24);
    end

    // Slot 1 of the same row keeps its own history
    do_update(32'h26, 1'b1, 1'b0);
    do_update(32'h26, 1'b0, 1'b0);
    do_update(32'h26, 1'b1, 1'b0);
    do_update(32'h26, 1'b1, 1'b0);
    vpc_i = 32'h26;
    #2;
    check_equal(int'(index_o[1]), 'hb, "slot 1 history");
    check_equal(int'(index_o[0]), 0, "slot 0 history");
    tick();
    check_all();

    // Debug mode blocks updates
    do_update(32'h24, 1'b1, 1'b1);
    do_update(32'h26, 1'b0, 1'b1);
    check_all();

    // Flush after training, with updates dropped during the clear
    start_flush();
    clearing = 1'b1;
    // Slot 0 of row 9 still points at a trained entry here
    vpc_i = 32'h24;
    #2;
    for (int s = 0; s < SLOTS; s++) begin
      check_equal(int'(bht_prediction_o[s].valid), 0,
                  $sformatf("valid slot %0d during clear", s));
    end
    tick();
    // Row 0 has already been walked by then
    for (int i = 0; i < 3; i++) begin
      do_update(32'h00, 1'b1, 1'b0);
    end
    wait_idle(cycles);
    check_equal(int'(cycles), int'(CLEAR_ROWS) - 4, "busy cycles after flush");
    clearing = 1'b0;
    clear_model();
    check_all();

    // Random traffic, skipped checks leave updates back to back
    for (int i = 0; i < 200; i++) begin
      pc = $urandom;
      do_update(pc, 1'($urandom), 1'b0);
      if ($urandom % 4 != 0) begin
        check_pc(pc);
      end
    end
    check_all();

    start_flush();
    wait_idle(cycles);
    check_equal(int'(cycles), int'(CLEAR_ROWS), "busy cycles after second flush");
    clear_model();
    check_all();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
logic/lbp_pkg.sv
logic/lbp_sat_counter.sv
logic/lbp_update_ctrl.sv
logic/lbp_history_table.sv
logic/lbp_pattern_table.sv
logic/lbp_top.sv
bench/tb_lbp_top.sv

//--- run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lbp_top -f sim.f -o tb_lbp_top \
  && ./obj_dir/tb_lbp_top > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0
